//--- list.f
logic/floatPkg.sv
logic/leadingZeroCount.sv
logic/operandAlign.sv
logic/significandAdder.sv
logic/resultNormalize.sv
logic/floatAdder.sv
bench/floatAdder_assertions.sv
bench/floatAdderTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = floatAdderTb
FILELIST = list.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@output="$$(./obj_dir/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q '^TESTS PASSED$$'

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- bench/floatAdderTb.sv
`timescale 1ns/10ps

module floatAdderTb;
	import floatPkg::*;

	localparam int clkPeriod = 8;
	localparam int sameSignOps = 2000;
	localparam int cancelOps = 1200;
	localparam int zeroAlignOps = 600;
	localparam int rangeOps = 400;
	localparam int burstOps = 200;
	localparam int gapOps = 100;
	localparam int maxGap = 2;
	localparam int totalOps = sameSignOps + cancelOps + zeroAlignOps + rangeOps + burstOps + gapOps;
	localparam int watchdogCycles = totalOps + gapOps * maxGap + 100; // Gaps add idle cycles.

	logic clk = 1'b0;
	logic rstN;
	logic inValid;
	floatWord opA;
	floatWord opB;
	logic outValid;
	floatWord result;

	logic [31:0] rngState = 32'h3a14;
	int cycleCount = 0;

	floatWord expQ[$];
	floatWord aQ[$];
	floatWord bQ[$];
	int issueQ[$];

	floatWord headExp;
	floatWord headA;
	floatWord headB;
	int headCycle;

	int strobeCount = 0;
	int monitorErrors = 0;
	int countErrors = 0;
	int totalIssued = 0;
	int testIssued = 0;
	int testStrobeBase = 0;
	int testErrorBase = 0;

	floatAdder floatAdder_i (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.opA(opA),
		.opB(opB),
		.outValid(outValid),
		.result(result)
	);

	always #(clkPeriod / 2) clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	function automatic logic [31:0] lcgNext();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic int randRange(input int lo, input int hi);
		logic [31:0] r;
		r = lcgNext();
		return lo + int'((r >> 8) % 32'(hi - lo + 1)); // The low LCG bits repeat too soon.
	endfunction

	function automatic logic randBit();
		logic [31:0] r;
		r = lcgNext();
		return r[31];
	endfunction

	function automatic logic [22:0] randFrac();
		return 23'(lcgNext() >> 9);
	endfunction

	function automatic floatWord makeWord(input logic s, input int e, input logic [22:0] f);
		floatWord w;
		w.fields.sign = s;
		w.fields.exponent = 8'(e);
		w.fields.fraction = f;
		return w;
	endfunction

	function automatic floatWord randomWord();
		logic s;
		int e;
		s = randBit();
		e = randRange(0, 254);
		return makeWord(s, e, randFrac());
	endfunction

	// Gives the operand value as a multiple of 2 to the power -149.
	function automatic logic signed [319:0] exactValue(input floatWord w);
		logic signed [319:0] v;
		v = '0;
		if (w.fields.exponent != '0) begin
			v = 320'({1'b1, w.fields.fraction});
			v = v << (int'(w.fields.exponent) - 1);
			if (w.fields.sign) begin
				v = -v;
			end
		end
		return v;
	endfunction

	function automatic floatWord modelSum(input floatWord a, input floatWord b);
		logic signed [319:0] total;
		logic [319:0] mag;
		logic [319:0] top;
		int lead;
		int e;
		floatWord r;
		total = exactValue(a) + exactValue(b);
		if (total[319]) begin
			mag = -total;
		end else begin
			mag = total;
		end
		lead = -1;
		for (int i = 0; i < 320; i++) begin
			if (mag[i]) begin
				lead = i;
			end
		end
		e = lead - 22; // A leading one at bit 23 means exponent 1.
		r.bits = '0;
		if (e >= expMax) begin
			r.fields.sign = total[319];
			r.fields.exponent = 8'(expMax);
		end else if (e > 0) begin
			top = mag >> (lead - 23);
			r.fields.sign = total[319];
			r.fields.exponent = 8'(e);
			r.fields.fraction = top[22:0]; // Bits below the 24 kept ones are dropped.
		end
		return r;
	endfunction

	function automatic int totalErrors();
		return monitorErrors + countErrors + floatAdder_i.floatAdderAssertions_i.failCount;
	endfunction

	task automatic compareResult(input floatWord expected, input floatWord actual,
			input floatWord a, input floatWord b);
		if (actual !== expected) begin
			$display("ERROR result: expected %h, got %h (opA %h, opB %h)",
				expected.bits, actual.bits, a.bits, b.bits);
			monitorErrors = monitorErrors + 1;
		end
	endtask

	task automatic compareCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("%s: %0d operations were issued but %0d results came back",
				name, expected, actual);
			countErrors = countErrors + 1;
		end
	endtask

	task automatic issueOp(input floatWord a, input floatWord b);
		@(posedge clk);
		#1;
		opA = a;
		opB = b;
		inValid = 1'b1;
		expQ.push_back(modelSum(a, b));
		aQ.push_back(a);
		bQ.push_back(b);
		issueQ.push_back(cycleCount);
		testIssued = testIssued + 1;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			inValid = 1'b0;
		end
	endtask

	task automatic finishTest(input string name);
		int errs;
		idleCycles(1);
		repeat (6) @(posedge clk); // The last result is due 3 cycles in, the rest catches strays.
		compareCount(name, testIssued, strobeCount - testStrobeBase);
		expQ.delete();
		aQ.delete();
		bQ.delete();
		issueQ.delete();
		errs = totalErrors() - testErrorBase;
		$display("%s: %0d operations, %0d errors", name, testIssued, errs);
		totalIssued = totalIssued + testIssued;
		testIssued = 0;
		testStrobeBase = strobeCount;
		testErrorBase = totalErrors();
	endtask

	task automatic runSameSign();
		logic s;
		int ea;
		int eb;
		floatWord a;
		floatWord b;
		for (int i = 0; i < sameSignOps; i++) begin
			s = randBit();
			ea = randRange(0, 254);
			if (i % 2 == 0) begin
				eb = ea - randRange(0, 2); // Close exponents make carries common.
			end else begin
				eb = ea - randRange(0, 40);
			end
			if (eb < 0) begin
				eb = 0;
			end
			a = makeWord(s, ea, randFrac());
			b = makeWord(s, eb, randFrac());
			if (randBit()) begin
				issueOp(b, a);
			end else begin
				issueOp(a, b);
			end
		end
	endtask

	task automatic runCancel();
		logic s;
		int ea;
		int eb;
		logic [22:0] fa;
		logic [22:0] fb;
		floatWord a;
		floatWord b;
		for (int i = 0; i < cancelOps; i++) begin
			s = randBit();
			ea = randRange(1, 254);
			eb = ea - randRange(0, 1);
			if (eb < 1) begin
				eb = 1;
			end
			fa = randFrac();
			if (i % 2 == 0) begin
				fb = fa ^ 23'(randRange(1, 255)); // Near-equal magnitudes leave many leading zeros.
			end else begin
				fb = randFrac();
			end
			a = makeWord(s, ea, fa);
			b = makeWord(~s, eb, fb);
			if (i % 16 == 0) begin
				b = a;
				b.fields.sign = ~s;
			end
			if (randBit()) begin
				issueOp(b, a);
			end else begin
				issueOp(a, b);
			end
		end
	endtask

	task automatic runZeroAlign();
		int diff;
		int ea;
		floatWord a;
		floatWord b;
		for (int i = 0; i < zeroAlignOps; i++) begin
			if (i % 2 == 0) begin
				a = makeWord(randBit(), 0, (i % 4 == 0) ? randFrac() : 23'd0);
				b = randomWord();
			end else begin
				diff = randRange(28, 60);
				ea = randRange(diff + 1, 254);
				a = makeWord(randBit(), ea, randFrac());
				b = makeWord(randBit(), ea - diff, randFrac());
			end
			if (randBit()) begin
				issueOp(b, a);
			end else begin
				issueOp(a, b);
			end
		end
	endtask

	task automatic runRange();
		logic s;
		int ea;
		logic [22:0] fa;
		floatWord a;
		floatWord b;
		for (int i = 0; i < rangeOps; i++) begin
			s = randBit();
			if (i % 2 == 0) begin
				a = makeWord(s, randRange(250, 254), randFrac());
				b = makeWord(s, randRange(250, 254), randFrac());
			end else begin
				ea = randRange(1, 3);
				fa = randFrac();
				a = makeWord(s, ea, fa);
				b = makeWord(~s, ea, fa ^ 23'(randRange(1, 4095)));
			end
			issueOp(a, b);
		end
	endtask

	task automatic runThroughput();
		for (int i = 0; i < burstOps; i++) begin
			issueOp(randomWord(), randomWord());
		end
		for (int i = 0; i < gapOps; i++) begin
			issueOp(randomWord(), randomWord());
			idleCycles(randRange(0, maxGap));
		end
	endtask

	always @(negedge clk) begin
		if (rstN && outValid) begin
			strobeCount = strobeCount + 1;
			if (expQ.size() == 0) begin
				$display("outValid rose at cycle %0d with no operation outstanding", cycleCount);
				monitorErrors = monitorErrors + 1;
			end else begin
				headExp = expQ.pop_front();
				headA = aQ.pop_front();
				headB = bQ.pop_front();
				headCycle = issueQ.pop_front();
				compareResult(headExp, result, headA, headB);
				if (cycleCount - headCycle != 3) begin
					$display("A result arrived %0d cycles after its operation instead of 3",
						cycleCount - headCycle);
					monitorErrors = monitorErrors + 1;
				end
			end
		end
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("The run did not finish within %0d cycles and was stopped", watchdogCycles);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int errs;
		rstN = 1'b0;
		inValid = 1'b0;
		opA = '0;
		opB = '0;
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;
		runSameSign();
		finishTest("same-sign addition");
		runCancel();
		finishTest("cancellation");
		runZeroAlign();
		finishTest("zeros and wide alignment");
		runRange();
		finishTest("overflow and underflow");
		runThroughput();
		finishTest("throughput");
		errs = totalErrors();
		$display("Summary: %0d operations, %0d results, %0d errors",
			totalIssued, strobeCount, errs);
		if (errs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- bench/floatAdder_assertions.sv
`timescale 1ns/10ps

module floatAdderAssertions (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic outValid,
	input floatPkg::floatWord result
);
	import floatPkg::*;

	int failCount = 0;

	// Three register stages sit between the two strobes.
	latencyMatch: assert property (@(posedge clk) disable iff (!rstN)
		outValid == $past(inValid, 3))
		else begin
			$error("outValid does not match inValid from three cycles before");
			failCount++;
		end

	quietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
		else begin
			$error("outValid is high while reset is asserted");
			failCount++;
		end

	// The adder never makes a NaN.
	legalEncoding: assert property (@(posedge clk) disable iff (!rstN)
		outValid |-> !((result.fields.exponent == 8'(expMax)) && (result.fields.fraction != '0)))
		else begin
			$error("result has an all-ones exponent with a nonzero fraction");
			failCount++;
		end

endmodule

bind floatAdder floatAdderAssertions floatAdderAssertions_i (
	.clk(clk),
	.rstN(rstN),
	.inValid(inValid),
	.outValid(outValid),
	.result(result)
);

//--- logic/floatAdder.sv
`timescale 1ns/10ps

module floatAdder (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input floatPkg::floatWord opA,
	input floatPkg::floatWord opB,
	output logic outValid,
	output floatPkg::floatWord result
);
	import floatPkg::*;

	logic alignValid;
	logic [sumWidth-1:0] bigSig;
	logic [sumWidth-1:0] smallSig;
	logic [expWidth-1:0] bigExp;
	logic bigSign;
	logic effSub;
	logic bothZero;

	logic sumValid;
	logic [sumWidth-1:0] sum;
	logic [expWidth-1:0] sumExp;
	logic sumSign;

	operandAlign operandAlign_i (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.opA(opA),
		.opB(opB),
		.alignValid(alignValid),
		.bigSig(bigSig),
		.smallSig(smallSig),
		.bigExp(bigExp),
		.bigSign(bigSign),
		.effSub(effSub),
		.bothZero(bothZero)
	);

	significandAdder significandAdder_i (
		.clk(clk),
		.rstN(rstN),
		.alignValid(alignValid),
		.bigSig(bigSig),
		.smallSig(smallSig),
		.bigExp(bigExp),
		.bigSign(bigSign),
		.effSub(effSub),
		.bothZero(bothZero),
		.sumValid(sumValid),
		.sum(sum),
		.sumExp(sumExp),
		.sumSign(sumSign)
	);

	resultNormalize resultNormalize_i (
		.clk(clk),
		.rstN(rstN),
		.sumValid(sumValid),
		.sum(sum),
		.sumExp(sumExp),
		.sumSign(sumSign),
		.outValid(outValid),
		.result(result)
	);

endmodule

//--- logic/resultNormalize.sv
`timescale 1ns/10ps

module resultNormalize (
	input logic clk,
	input logic rstN,
	input logic sumValid,
	input logic [floatPkg::sumWidth-1:0] sum,
	input logic [floatPkg::expWidth-1:0] sumExp,
	input logic sumSign,
	output logic outValid,
	output floatPkg::floatWord result
);
	import floatPkg::*;

	logic [lzcWidth-1:0] zeroCount;
	logic cancelled;
	logic [sumWidth-1:0] normSum;
	logic [expWidth+1:0] newExp;
	logic underflow;
	logic overflow;
	floatWord packed_;

	leadingZeroCount leadingZeroCount_i (
		.value(sum),
		.count(zeroCount),
		.allZero(cancelled)
	);

	// After this shift the leading one sits in the carry position.
	assign normSum = sum << zeroCount;

	// Two extra bits hold the sign and headroom of the adjusted exponent.
	assign newExp = {2'b00, sumExp} + (expWidth+2)'(1) - (expWidth+2)'(zeroCount);
	assign underflow = newExp[expWidth+1] || (newExp == '0);
	assign overflow = !newExp[expWidth+1] && (newExp >= (expWidth+2)'(expMax));

	always_comb begin
		if (cancelled || underflow) begin
			packed_.bits = '0;
		end else if (overflow) begin
			packed_.fields.sign = sumSign;
			packed_.fields.exponent = expWidth'(expMax);
			packed_.fields.fraction = '0;
		end else begin
			packed_.fields.sign = sumSign;
			packed_.fields.exponent = newExp[expWidth-1:0];
			packed_.fields.fraction = normSum[sumWidth-2 -: fracWidth]; // Lower bits are truncated.
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= sumValid;
		end
	end

	always_ff @(posedge clk) begin
		if (sumValid) begin
			result <= packed_;
		end
	end

endmodule

//--- logic/significandAdder.sv
`timescale 1ns/10ps

module significandAdder (
	input logic clk,
	input logic rstN,
	input logic alignValid,
	input logic [floatPkg::sumWidth-1:0] bigSig,
	input logic [floatPkg::sumWidth-1:0] smallSig,
	input logic [floatPkg::expWidth-1:0] bigExp,
	input logic bigSign,
	input logic effSub,
	input logic bothZero,
	output logic sumValid,
	output logic [floatPkg::sumWidth-1:0] sum,
	output logic [floatPkg::expWidth-1:0] sumExp,
	output logic sumSign
);
	import floatPkg::*;

	logic [sumWidth-1:0] rawSum;

	// Stage 1 ordered the operands, so the difference never goes negative.
	// The carry bit on top absorbs the overflow of an addition.
	always_comb begin
		if (effSub) begin
			rawSum = bigSig - smallSig;
		end else begin
			rawSum = bigSig + smallSig;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			sumValid <= 1'b0;
		end else begin
			sumValid <= alignValid;
		end
	end

	always_ff @(posedge clk) begin
		if (alignValid) begin
			sum <= rawSum;
			sumExp <= bigExp;
			sumSign <= bigSign & ~bothZero; // Two zeros give plus zero.
		end
	end

endmodule

//--- logic/operandAlign.sv
`timescale 1ns/10ps

module operandAlign (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input floatPkg::floatWord opA,
	input floatPkg::floatWord opB,
	output logic alignValid,
	output logic [floatPkg::sumWidth-1:0] bigSig,
	output logic [floatPkg::sumWidth-1:0] smallSig,
	output logic [floatPkg::expWidth-1:0] bigExp,
	output logic bigSign,
	output logic effSub,
	output logic bothZero
);
	import floatPkg::*;

	logic aZero;
	logic bZero;
	logic [sigWidth-1:0] aSig;
	logic [sigWidth-1:0] bSig;
	logic aLarger;
	logic [expWidth-1:0] largeExp;
	logic [expWidth-1:0] lesserExp;
	logic [expWidth-1:0] expDiff;
	logic [sigWidth-1:0] largeSig;
	logic [sigWidth-1:0] lesserSig;
	logic [sumWidth-1:0] lesserExt;
	logic [sumWidth-1:0] lostMask;
	logic [sumWidth-1:0] shifted;
	logic sticky;

	// An exponent of zero is read as zero, so subnormals flush here.
	assign aZero = (opA.fields.exponent == '0);
	assign bZero = (opB.fields.exponent == '0);
	assign aSig = aZero ? '0 : {1'b1, opA.fields.fraction};
	assign bSig = bZero ? '0 : {1'b1, opB.fields.fraction};

	// Exponent first, then significand; a tie keeps opA on top.
	assign aLarger = {opA.fields.exponent, aSig} >= {opB.fields.exponent, bSig};

	always_comb begin
		if (aLarger) begin
			largeExp = opA.fields.exponent;
			lesserExp = opB.fields.exponent;
			largeSig = aSig;
			lesserSig = bSig;
		end else begin
			largeExp = opB.fields.exponent;
			lesserExp = opA.fields.exponent;
			largeSig = bSig;
			lesserSig = aSig;
		end
	end

	assign expDiff = largeExp - lesserExp;
	assign lesserExt = {1'b0, lesserSig, {guardBits{1'b0}}};

	// A difference of sumWidth or more clears the shift and opens the whole mask.
	assign shifted = lesserExt >> expDiff;
	assign lostMask = ~({sumWidth{1'b1}} << expDiff);
	assign sticky = |(lesserExt & lostMask);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			alignValid <= 1'b0;
		end else begin
			alignValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			bigSig <= {1'b0, largeSig, {guardBits{1'b0}}};
			smallSig <= {shifted[sumWidth-1:1], shifted[0] | sticky}; // Sticky joins the lowest guard bit.
			bigExp <= largeExp;
			bigSign <= aLarger ? opA.fields.sign : opB.fields.sign;
			effSub <= opA.fields.sign ^ opB.fields.sign;
			bothZero <= aZero & bZero;
		end
	end

endmodule

//--- logic/leadingZeroCount.sv
`timescale 1ns/10ps

module leadingZeroCount (
	input logic [floatPkg::sumWidth-1:0] value,
	output logic [floatPkg::lzcWidth-1:0] count,
	output logic allZero
);
	import floatPkg::*;

	// Scans upward so that the highest set bit is the last one to write count.
	always_comb begin
		count = '0;
		allZero = 1'b1;
		for (int i = 0; i < sumWidth; i++) begin
			if (value[i]) begin
				count = lzcWidth'(sumWidth - 1 - i);
				allZero = 1'b0;
			end
		end
	end

endmodule

//--- logic/floatPkg.sv
package floatPkg;

	localparam int expWidth = 8;
	localparam int fracWidth = 23;
	localparam int sigWidth = 24; // Fraction plus the hidden one.
	localparam int guardBits = 3;

	// One carry bit above the significand and the guard bits below it.
	localparam int sumWidth = 1 + sigWidth + guardBits;

	localparam int lzcWidth = 5; // Enough to count up to sumWidth - 1 zeros.
	localparam int expMax = 255;

	typedef struct packed {
		logic sign;
		logic [expWidth-1:0] exponent;
		logic [fracWidth-1:0] fraction;
	} floatFields;

	// A single precision word, seen either as raw bits or as its IEEE fields.
	typedef union packed {
		logic [1+expWidth+fracWidth-1:0] bits;
		floatFields fields;
	} floatWord;

endpackage
